// ==== src/spi_cfg_pkg.sv ====
//////////////////////////////
// Bus and buffer constants for the SPI master
// Data, length and wait widths with their types
//////////////////////////////
package spi_cfg_pkg;

  //////////////////////////////
  // SCK timing
  //////////////////////////////
  localparam int SCK_RATIO = 8;                  // System clocks per SCK period
  localparam int SCK_HALF  = SCK_RATIO / 2;      // Phase where SCK goes high
  localparam int PHASE_W   = $clog2(SCK_RATIO);  // Phase counter width

  //////////////////////////////
  // Data and command widths
  //////////////////////////////
  localparam int BYTE_W = 8;
  localparam int LEN_W  = 4;                     // Up to 15 bytes per direction
  localparam int WAIT_W = 2;                     // Up to 3 idle SCK periods

  // Buffer depths, RX kept shallow so overflow can happen
  localparam int TX_DEPTH = 16;
  localparam int RX_DEPTH = 8;

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [LEN_W-1:0]  len_t;
  typedef logic [WAIT_W-1:0] wait_t;

endpackage : spi_cfg_pkg

// ==== src/spi_seq_pkg.sv ====
//////////////////////////////
// Frame sequencer states and timing constants
//////////////////////////////
package spi_seq_pkg;

  // Frame states in the order they run
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START_D,     // CSN high guard
    ST_START_S,     // CSN low guard
    ST_TX,
    ST_WAIT,
    ST_RX,
    ST_STOP_S,      // CSN low guard
    ST_STOP_D       // CSN high guard
  } seq_state_t;

  localparam int GUARD_PERIODS = 4;  // SCK periods per guard state

  // Longest state is 8 bits times the largest byte count
  localparam int TIMER_W = $clog2(8 * ((1 << spi_cfg_pkg::LEN_W) - 1) + 1);

endpackage : spi_seq_pkg

// ==== src/spi_byte_fifo.sv ====
//////////////////////////////
// Synchronous byte FIFO with first-word fall-through
//////////////////////////////
`timescale 1ns/1ns

module spi_byte_fifo #(
  parameter int DEPTH = 16
) (
  input  logic               i_ext_spi_clk_x,
  input  logic               i_srst,
  input  logic               wr_en_i,
  input  spi_cfg_pkg::byte_t wr_data_i,
  input  logic               rd_en_i,
  output spi_cfg_pkg::byte_t rd_data_o,
  output logic               full_o,
  output logic               empty_o
);

  localparam int AW = $clog2(DEPTH);      // Pointer width
  localparam int CW = $clog2(DEPTH + 1);  // Occupancy width, holds DEPTH itself

  spi_cfg_pkg::byte_t mem [DEPTH];
  logic [AW-1:0]      wr_ptr;
  logic [AW-1:0]      rd_ptr;
  logic [CW-1:0]      count;
  logic               wr_ok;
  logic               rd_ok;

  assign wr_ok   = wr_en_i && !full_o;    // Drop writes into a full buffer
  assign rd_ok   = rd_en_i && !empty_o;   // Drop reads from an empty one
  assign full_o  = (count == CW'(DEPTH));
  assign empty_o = (count == '0);
  assign rd_data_o = mem[rd_ptr];         // Head always visible

  // Storage, no reset on payload
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (wr_ok) mem[wr_ptr] <= wr_data_i;
  end

  // Pointers and occupancy
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_ok) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (wr_ok && !rd_ok)      count <= count + 1'b1;
      else if (rd_ok && !wr_ok) count <= count - 1'b1;  // Both at once, no change
    end
  end

endmodule : spi_byte_fifo

// ==== src/spi_phase_gen.sv ====
//////////////////////////////
// SCK phase counter with edge strobes
//////////////////////////////
`timescale 1ns/1ns

module spi_phase_gen (
  input  logic i_ext_spi_clk_x,
  input  logic i_srst,
  output logic fall_ce_o,
  output logic rise_ce_o,
  output logic sck_phase_hi_o
);

  logic [spi_cfg_pkg::PHASE_W-1:0] phase;

  // Free running, one lap per SCK period
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      phase <= '0;
    end else if (phase == spi_cfg_pkg::PHASE_W'(spi_cfg_pkg::SCK_RATIO - 1)) begin
      phase <= '0;
    end else begin
      phase <= phase + 1'b1;
    end
  end

  // Decode, SCK falls entering phase 0 and rises at the half point
  assign fall_ce_o      = (phase == '0);
  assign rise_ce_o      = (phase == spi_cfg_pkg::PHASE_W'(spi_cfg_pkg::SCK_HALF));
  assign sck_phase_hi_o = (phase >= spi_cfg_pkg::PHASE_W'(spi_cfg_pkg::SCK_HALF));

endmodule : spi_phase_gen

// ==== src/spi_cmd_regs.sv ====
//////////////////////////////
// Command latch and start request holder
//////////////////////////////
`timescale 1ns/1ns

module spi_cmd_regs (
  input  logic               i_ext_spi_clk_x,
  input  logic               i_srst,
  input  logic               go_i,
  input  spi_cfg_pkg::len_t  tx_len_i,
  input  spi_cfg_pkg::len_t  rx_len_i,
  input  spi_cfg_pkg::wait_t wait_cyc_i,
  input  logic               seq_idle_i,
  input  logic               start_ack_i,
  output spi_cfg_pkg::len_t  tx_len_o,
  output spi_cfg_pkg::len_t  rx_len_o,
  output spi_cfg_pkg::wait_t wait_cyc_o,
  output logic               start_req_o,
  output logic               spi_idle_o
);

  logic go_ok;

  // Busy as soon as a request is pending, before the sequencer moves
  assign spi_idle_o = seq_idle_i && !start_req_o;
  assign go_ok      = go_i && spi_idle_o;     // Strobe mid frame is dropped

  // Hold the go pulse until the sequencer picks it up on its next fall edge
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      start_req_o <= 1'b0;
      tx_len_o    <= '0;
      rx_len_o    <= '0;
      wait_cyc_o  <= '0;
    end else if (go_ok) begin
      start_req_o <= 1'b1;
      tx_len_o    <= tx_len_i;                // Stable for the whole frame
      rx_len_o    <= rx_len_i;
      wait_cyc_o  <= wait_cyc_i;
    end else if (start_ack_i) begin
      start_req_o <= 1'b0;
    end
  end

endmodule : spi_cmd_regs

// ==== src/spi_sequencer.sv ====
//////////////////////////////
// Frame FSM and SCK period timer
// Drives CSN, SCK, COPI, TX pops and RX sample strobes
//////////////////////////////
`timescale 1ns/1ns

module spi_sequencer (
  input  logic               i_ext_spi_clk_x,
  input  logic               i_srst,
  input  logic               fall_ce_i,
  input  logic               rise_ce_i,
  input  logic               sck_phase_hi_i,
  input  logic               start_req_i,
  input  spi_cfg_pkg::len_t  tx_len_i,
  input  spi_cfg_pkg::len_t  rx_len_i,
  input  spi_cfg_pkg::wait_t wait_cyc_i,
  input  spi_cfg_pkg::byte_t tx_head_i,
  input  logic               tx_empty_i,
  output logic               start_ack_o,
  output logic               seq_idle_o,
  output logic               tx_pop_o,
  output logic               rx_sample_o,
  output logic               sck_o,
  output logic               csn_o,
  output logic               copi_o
);

  localparam int TW = spi_seq_pkg::TIMER_W;

  spi_seq_pkg::seq_state_t state;
  spi_seq_pkg::seq_state_t nx_state;
  spi_seq_pkg::seq_state_t after_tx;   // Where to go once TX is done or skipped
  logic [TW-1:0]           timer;      // SCK periods spent in current state
  logic [TW-1:0]           tx_last;
  logic [TW-1:0]           rx_last;
  logic [TW-1:0]           wait_last;
  logic                    guard_done;
  logic [2:0]              bit_idx;

  //////////////////////////////
  // Period end values
  //////////////////////////////
  assign tx_last    = TW'({tx_len_i, 3'b000}) - 1'b1;   // 8 periods per byte
  assign rx_last    = TW'({rx_len_i, 3'b000}) - 1'b1;
  assign wait_last  = TW'(wait_cyc_i) - 1'b1;
  assign guard_done = (timer == TW'(spi_seq_pkg::GUARD_PERIODS - 1));

  // WAIT only makes sense ahead of an RX phase
  always_comb begin
    if (rx_len_i == '0)        after_tx = spi_seq_pkg::ST_STOP_S;
    else if (wait_cyc_i == '0) after_tx = spi_seq_pkg::ST_RX;
    else                       after_tx = spi_seq_pkg::ST_WAIT;
  end

  //////////////////////////////
  // Next state
  //////////////////////////////
  always_comb begin
    nx_state = state;   // Stay by default
    case (state)
      spi_seq_pkg::ST_IDLE:    if (start_req_i) nx_state = spi_seq_pkg::ST_START_D;
      spi_seq_pkg::ST_START_D: if (guard_done) nx_state = spi_seq_pkg::ST_START_S;
      spi_seq_pkg::ST_START_S: begin
        if (guard_done) nx_state = (tx_len_i != '0) ? spi_seq_pkg::ST_TX : after_tx;
      end
      spi_seq_pkg::ST_TX:      if (timer == tx_last) nx_state = after_tx;
      spi_seq_pkg::ST_WAIT:    if (timer == wait_last) nx_state = spi_seq_pkg::ST_RX;
      spi_seq_pkg::ST_RX:      if (timer == rx_last) nx_state = spi_seq_pkg::ST_STOP_S;
      spi_seq_pkg::ST_STOP_S:  if (guard_done) nx_state = spi_seq_pkg::ST_STOP_D;
      spi_seq_pkg::ST_STOP_D:  if (guard_done) nx_state = spi_seq_pkg::ST_IDLE;
      default:                 nx_state = spi_seq_pkg::ST_IDLE;
    endcase
  end

  // State and timer move only on the SCK falling strobe
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst) begin
      state <= spi_seq_pkg::ST_IDLE;
      timer <= '0;
    end else if (fall_ce_i) begin
      state <= nx_state;
      if (nx_state != state || state == spi_seq_pkg::ST_IDLE) timer <= '0;
      else                                                    timer <= timer + 1'b1;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////
  assign seq_idle_o  = (state == spi_seq_pkg::ST_IDLE);
  assign start_ack_o = fall_ce_i && seq_idle_o && start_req_i;  // Same edge as leaving IDLE

  // SCK toggles only in the data phases
  assign sck_o = sck_phase_hi_i && (state == spi_seq_pkg::ST_TX ||
                                    state == spi_seq_pkg::ST_WAIT ||
                                    state == spi_seq_pkg::ST_RX);

  // CSN high only in IDLE and the outer guards
  assign csn_o = (state == spi_seq_pkg::ST_IDLE ||
                  state == spi_seq_pkg::ST_START_D ||
                  state == spi_seq_pkg::ST_STOP_D);

  // MSB first, bit index follows the timer
  assign bit_idx = 3'd7 - timer[2:0];
  assign copi_o  = (state == spi_seq_pkg::ST_TX) && !tx_empty_i && tx_head_i[bit_idx];

  // Pop on the fall edge closing each byte
  assign tx_pop_o = fall_ce_i && (state == spi_seq_pkg::ST_TX) &&
                    (timer[2:0] == 3'd7) && !tx_empty_i;

  assign rx_sample_o = rise_ce_i && (state == spi_seq_pkg::ST_RX);

endmodule : spi_sequencer

// ==== src/spi_rx_shifter.sv ====
//////////////////////////////
// CIPO shift register feeding the RX FIFO
//////////////////////////////
`timescale 1ns/1ns

module spi_rx_shifter (
  input  logic               i_ext_spi_clk_x,
  input  logic               i_srst,
  input  logic               rx_sample_i,
  input  logic               cipo_i,
  input  logic               rx_full_i,
  input  logic               seq_idle_i,
  output logic               rx_wr_o,
  output spi_cfg_pkg::byte_t rx_byte_o
);

  localparam int BW = $clog2(spi_cfg_pkg::BYTE_W);

  logic [BW-1:0] bit_cnt;
  logic          last_bit;

  assign last_bit = (bit_cnt == BW'(spi_cfg_pkg::BYTE_W - 1));

  // Payload shift, MSB arrives first
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (rx_sample_i) rx_byte_o <= {rx_byte_o[spi_cfg_pkg::BYTE_W-2:0], cipo_i};
  end

  // Bit count and write strobe
  always_ff @(posedge i_ext_spi_clk_x) begin
    if (i_srst || seq_idle_i) begin
      bit_cnt <= '0;              // Each frame starts on a byte boundary
      rx_wr_o <= 1'b0;
    end else begin
      rx_wr_o <= rx_sample_i && last_bit && !rx_full_i;   // Full FIFO loses the byte
      if (rx_sample_i) bit_cnt <= bit_cnt + 1'b1;         // Wraps after 8 bits
    end
  end

endmodule : spi_rx_shifter

// ==== src/spi_master_top.sv ====
//////////////////////////////
// SPI master top, FIFOs, command block,
// phase generator, sequencer and RX shifter
//////////////////////////////
`timescale 1ns/1ns

module spi_master_top (
  input  logic               i_ext_spi_clk_x,
  input  logic               i_srst,
  input  logic               go_i,
  input  spi_cfg_pkg::len_t  tx_len_i,
  input  spi_cfg_pkg::len_t  rx_len_i,
  input  spi_cfg_pkg::wait_t wait_cyc_i,
  input  spi_cfg_pkg::byte_t tx_data_i,
  input  logic               tx_enqueue_i,
  output logic               tx_ready_o,
  output spi_cfg_pkg::byte_t rx_data_o,
  output logic               rx_avail_o,
  input  logic               rx_dequeue_i,
  output logic               spi_idle_o,
  output logic               sck_o,
  output logic               csn_o,
  output logic               copi_o,
  input  logic               cipo_i
);

  spi_cfg_pkg::byte_t tx_head, rx_byte;
  spi_cfg_pkg::len_t  tx_len, rx_len;
  spi_cfg_pkg::wait_t wait_cyc;
  logic tx_full, tx_empty, tx_pop;
  logic rx_full, rx_empty, rx_wr, rx_sample;
  logic fall_ce, rise_ce, sck_phase_hi;
  logic start_req, start_ack, seq_idle;

  assign tx_ready_o = !tx_full;
  assign rx_avail_o = !rx_empty;

  //////////////////////////////
  // Buffers
  //////////////////////////////
  spi_byte_fifo #(.DEPTH(spi_cfg_pkg::TX_DEPTH)) u_tx_fifo (
    .i_ext_spi_clk_x, .i_srst, .wr_en_i(tx_enqueue_i), .wr_data_i(tx_data_i),
    .rd_en_i(tx_pop), .rd_data_o(tx_head), .full_o(tx_full), .empty_o(tx_empty));

  spi_byte_fifo #(.DEPTH(spi_cfg_pkg::RX_DEPTH)) u_rx_fifo (
    .i_ext_spi_clk_x, .i_srst, .wr_en_i(rx_wr), .wr_data_i(rx_byte),
    .rd_en_i(rx_dequeue_i), .rd_data_o(rx_data_o), .full_o(rx_full), .empty_o(rx_empty));

  //////////////////////////////
  // Control
  //////////////////////////////
  spi_phase_gen u_phase (
    .i_ext_spi_clk_x, .i_srst, .fall_ce_o(fall_ce), .rise_ce_o(rise_ce),
    .sck_phase_hi_o(sck_phase_hi));

  spi_cmd_regs u_cmd (
    .i_ext_spi_clk_x, .i_srst, .go_i, .tx_len_i, .rx_len_i, .wait_cyc_i,
    .seq_idle_i(seq_idle), .start_ack_i(start_ack), .tx_len_o(tx_len),
    .rx_len_o(rx_len), .wait_cyc_o(wait_cyc), .start_req_o(start_req), .spi_idle_o);

  spi_sequencer u_seq (
    .i_ext_spi_clk_x, .i_srst, .fall_ce_i(fall_ce), .rise_ce_i(rise_ce),
    .sck_phase_hi_i(sck_phase_hi), .start_req_i(start_req), .tx_len_i(tx_len),
    .rx_len_i(rx_len), .wait_cyc_i(wait_cyc), .tx_head_i(tx_head), .tx_empty_i(tx_empty),
    .start_ack_o(start_ack), .seq_idle_o(seq_idle), .tx_pop_o(tx_pop),
    .rx_sample_o(rx_sample), .sck_o, .csn_o, .copi_o);

  spi_rx_shifter u_rx (
    .i_ext_spi_clk_x, .i_srst, .rx_sample_i(rx_sample), .cipo_i, .rx_full_i(rx_full),
    .seq_idle_i(seq_idle), .rx_wr_o(rx_wr), .rx_byte_o(rx_byte));

endmodule : spi_master_top

// ==== verification/spi_slave_model.sv ====
//////////////////////////////
// Behavioral SPI slave, Mode 0
// Records COPI bytes, drives CIPO, counts edges
//////////////////////////////
`timescale 1ns/1ns

module spi_slave_model (
  input  logic sck_i,
  input  logic csn_i,
  input  logic copi_i,
  input  int   skip_i,          // SCK rises before CIPO data starts
  output logic cipo_o
);

  logic [7:0] pattern [16];     // Bytes sent back on CIPO
  logic [7:0] copi_bytes [$];   // Whole bytes seen on COPI in this frame
  logic [7:0] shift_in;
  logic       sck_q;
  logic       csn_q;
  int         rise_cnt;         // SCK rises since CSN fell
  int         csn_rise_cnt;     // Running totals over the whole run
  int         csn_fall_cnt;

  // CIPO bit at a position in the outgoing stream, zero outside it
  function automatic logic pattern_bit(input int idx);
    if (idx < 0 || idx >= 128) return 1'b0;
    return pattern[4'(idx / 8)][3'(7 - idx % 8)];
  endfunction

  // One process owns all state, edges found by comparing with last values
  initial begin
    cipo_o       = 1'b0;
    shift_in     = '0;
    rise_cnt     = 0;
    csn_rise_cnt = 0;
    csn_fall_cnt = 0;
    sck_q        = sck_i;
    csn_q        = csn_i;
    for (int i = 0; i < 16; i++) begin
      pattern[4'(i)] = 8'(i * 59) ^ 8'hC5;   // Distinct byte per slot
    end
    forever begin
      @(sck_i or csn_i);
      if (csn_q === 1'b1 && csn_i === 1'b0) begin   // Frame start
        csn_fall_cnt++;
        rise_cnt = 0;
        copi_bytes.delete();
        cipo_o = pattern_bit(-skip_i);              // First bit when no lead-in
      end
      if (csn_q === 1'b0 && csn_i === 1'b1) csn_rise_cnt++;
      if (sck_q === 1'b0 && sck_i === 1'b1) begin   // Sample COPI on rise
        shift_in = {shift_in[6:0], copi_i};
        rise_cnt++;
        if (rise_cnt % 8 == 0) copi_bytes.push_back(shift_in);
      end
      if (sck_q === 1'b1 && sck_i === 1'b0) cipo_o = pattern_bit(rise_cnt - skip_i);
      sck_q = sck_i;
      csn_q = csn_i;
    end
  end

endmodule : spi_slave_model

// ==== verification/tb_spi_master.sv ====
//////////////////////////////
// SPI master testbench
// Clock, reset, directed tests, checks, timeout
//////////////////////////////
`timescale 1ns/1ns

module tb_spi_master;

  localparam int TIMEOUT_CYCLES = 20000;   // Five frames of at most 2000 cycles plus margin

  logic               clk;
  logic               srst;
  logic               go;
  spi_cfg_pkg::len_t  tx_len;
  spi_cfg_pkg::len_t  rx_len;
  spi_cfg_pkg::wait_t wait_cyc;
  spi_cfg_pkg::byte_t tx_data;
  logic               tx_enqueue;
  logic               tx_ready;
  spi_cfg_pkg::byte_t rx_data;
  logic               rx_avail;
  logic               rx_dequeue;
  logic               spi_idle;
  logic               sck;
  logic               csn;
  logic               copi;
  logic               cipo;
  int                 slave_skip;
  int                 seed = 12283;
  int                 cycle_cnt = 0;
  int                 csn_falls0;          // CSN edge totals when a frame starts
  int                 csn_rises0;
  logic [7:0]         sent_q [$];          // TX bytes in enqueue order

  spi_master_top u_dut (
    .i_ext_spi_clk_x(clk),
    .i_srst(srst),
    .go_i(go),
    .tx_len_i(tx_len),
    .rx_len_i(rx_len),
    .wait_cyc_i(wait_cyc),
    .tx_data_i(tx_data),
    .tx_enqueue_i(tx_enqueue),
    .tx_ready_o(tx_ready),
    .rx_data_o(rx_data),
    .rx_avail_o(rx_avail),
    .rx_dequeue_i(rx_dequeue),
    .spi_idle_o(spi_idle),
    .sck_o(sck),
    .csn_o(csn),
    .copi_o(copi),
    .cipo_i(cipo)
  );

  spi_slave_model u_slave (
    .sck_i(sck),
    .csn_i(csn),
    .copi_i(copi),
    .skip_i(slave_skip),
    .cipo_o(cipo)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog
  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles with tests still running", TIMEOUT_CYCLES);
    $display("Checks failed");
    $fatal(1);
  end

  task automatic check_eq(input string name, input logic [31:0] exp_v,
                          input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("Error: %s expected %0h actual %0h", name, exp_v, act_v);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  //////////////////////////////
  // Bus helpers that all start and end on a falling clock edge
  //////////////////////////////
  task automatic push_tx_byte(input logic [7:0] data);
    tx_data    = data;
    tx_enqueue = 1'b1;
    @(negedge clk);
    tx_enqueue = 1'b0;
  endtask

  task automatic pop_rx_byte(input string name, input logic [7:0] exp_v);
    check_eq({name, " avail"}, 1, 32'(rx_avail));
    check_eq({name, " data"}, 32'(exp_v), 32'(rx_data));   // Head visible before pop
    rx_dequeue = 1'b1;
    @(negedge clk);
    rx_dequeue = 1'b0;
  endtask

  task automatic send_go(input int tx_n, input int rx_n, input int waits);
    tx_len   = spi_cfg_pkg::len_t'(tx_n);
    rx_len   = spi_cfg_pkg::len_t'(rx_n);
    wait_cyc = spi_cfg_pkg::wait_t'(waits);
    go       = 1'b1;
    @(negedge clk);
    go       = 1'b0;
  endtask

  task automatic start_frame(input string name, input int tx_n, input int rx_n,
                             input int waits, input int skip);
    csn_falls0 = u_slave.csn_fall_cnt;
    csn_rises0 = u_slave.csn_rise_cnt;
    slave_skip = skip;
    send_go(tx_n, rx_n, waits);
    check_eq({name, " busy"}, 0, 32'(spi_idle));   // Request pending at once
  endtask

  // Frame is over once idle returns and CSN must have toggled exactly once
  task automatic end_frame(input string name);
    while (spi_idle !== 1'b1) @(negedge clk);
    check_eq({name, " csn falls"}, csn_falls0 + 1, u_slave.csn_fall_cnt);
    check_eq({name, " csn rises"}, csn_rises0 + 1, u_slave.csn_rise_cnt);
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic reset_values_test();
    check_eq("reset csn", 1, 32'(csn));
    check_eq("reset sck", 0, 32'(sck));
    check_eq("reset copi", 0, 32'(copi));
    check_eq("reset idle", 1, 32'(spi_idle));
    check_eq("reset rx_avail", 0, 32'(rx_avail));
    check_eq("reset tx_ready", 1, 32'(tx_ready));
  endtask

  task automatic tx_only_test();
    sent_q.delete();
    for (int i = 0; i < 3; i++) begin
      sent_q.push_back(8'($random(seed)));
      push_tx_byte(sent_q[i]);
    end
    start_frame("tx_only", 3, 0, 0, 0);
    end_frame("tx_only");
    check_eq("tx_only edges", 8 * 3, u_slave.rise_cnt);
    check_eq("tx_only bytes", 3, u_slave.copi_bytes.size());
    for (int i = 0; i < 3; i++) begin
      check_eq("tx_only copi", 32'(sent_q[i]), 32'(u_slave.copi_bytes[i]));
    end
  endtask

  task automatic tx_wait_rx_test();
    sent_q.delete();
    for (int i = 0; i < 2; i++) begin
      sent_q.push_back(8'($random(seed)));
      push_tx_byte(sent_q[i]);
    end
    start_frame("tx_wait_rx", 2, 4, 2, 8 * 2 + 2);   // CIPO data after TX and waits
    end_frame("tx_wait_rx");
    check_eq("tx_wait_rx edges", 8 * 2 + 2 + 8 * 4, u_slave.rise_cnt);
    for (int i = 0; i < 2; i++) begin
      check_eq("tx_wait_rx copi", 32'(sent_q[i]), 32'(u_slave.copi_bytes[i]));
    end
    for (int i = 0; i < 4; i++) pop_rx_byte("tx_wait_rx rx", u_slave.pattern[4'(i)]);
    check_eq("tx_wait_rx drained", 0, 32'(rx_avail));
  endtask

  task automatic rx_overflow_test();
    start_frame("rx_overflow", 0, 10, 0, 0);
    end_frame("rx_overflow");
    check_eq("rx_overflow edges", 8 * 10, u_slave.rise_cnt);
    for (int i = 0; i < spi_cfg_pkg::RX_DEPTH; i++) begin
      pop_rx_byte("rx_overflow rx", u_slave.pattern[4'(i)]);
    end
    check_eq("rx_overflow avail", 0, 32'(rx_avail));   // Last two bytes were lost
  endtask

  task automatic tx_full_test();
    sent_q.delete();
    for (int i = 0; i < spi_cfg_pkg::TX_DEPTH; i++) begin
      sent_q.push_back(8'($random(seed)));
      push_tx_byte(sent_q[i]);
    end
    check_eq("tx_full ready", 0, 32'(tx_ready));
    push_tx_byte(8'($random(seed)) | 8'h01);   // Nonzero so a kept copy would show
    start_frame("tx_full", 15, 0, 0, 0);
    while (csn !== 1'b0) @(negedge clk);
    send_go(2, 3, 1);                         // Stray strobe inside the frame
    end_frame("tx_full");
    check_eq("tx_full edges", 8 * 15, u_slave.rise_cnt);
    for (int i = 0; i < 15; i++) begin
      check_eq("tx_full copi", 32'(sent_q[i]), 32'(u_slave.copi_bytes[i]));
    end
    check_eq("tx_full ready after", 1, 32'(tx_ready));
    repeat (2 * spi_cfg_pkg::SCK_RATIO) @(negedge clk);
    check_eq("tx_full stray go", 1, 32'(spi_idle));
    // Byte 16 remains and then an empty FIFO sends zeros
    start_frame("tx_full tail", 2, 0, 0, 0);
    end_frame("tx_full tail");
    check_eq("tx_full tail edges", 8 * 2, u_slave.rise_cnt);
    check_eq("tx_full tail byte", 32'(sent_q[15]), 32'(u_slave.copi_bytes[0]));
    check_eq("tx_full dropped", 0, 32'(u_slave.copi_bytes[1]));
  endtask

  initial begin
    srst       = 1'b1;
    go         = 1'b0;
    tx_len     = '0;
    rx_len     = '0;
    wait_cyc   = '0;
    tx_data    = '0;
    tx_enqueue = 1'b0;
    rx_dequeue = 1'b0;
    slave_skip = 0;
    repeat (16) @(negedge clk);
    srst = 1'b0;
    @(negedge clk);
    reset_values_test();
    tx_only_test();
    tx_wait_rx_test();
    rx_overflow_test();
    tx_full_test();
    $display("All checks passed");
    $finish;
  end

endmodule : tb_spi_master

// ==== src.f ====
src/spi_cfg_pkg.sv
src/spi_seq_pkg.sv
src/spi_byte_fifo.sv
src/spi_phase_gen.sv
src/spi_cmd_regs.sv
src/spi_sequencer.sv
src/spi_rx_shifter.sv
src/spi_master_top.sv
verification/spi_slave_model.sv
verification/tb_spi_master.sv

// ==== Makefile ====
# Verilator build and run for the SPI master testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_master
FLIST     ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All checks passed

SRCS := $(shell cat $(FLIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
